// ==== hdl/vend_pkg.sv ====
package vend_pkg;

    // ==========================================================
    // Machine types
    // ==========================================================

    // Credit in currency units, 0 to 100
    typedef logic [6:0] credit_t;

    typedef enum logic [1:0] {
        DRINK_0,
        DRINK_1,
        DRINK_2,
        DRINK_3
    } drink_e;

    typedef enum logic {
        COLLECT,
        REFUND
    } state_e;

    // Single-cycle press pulses from the button conditioners
    typedef struct packed {
        logic coin_5;
        logic coin_15;
        logic coin_50;
        logic cancel;
    } buttons_t;

    typedef struct packed {
        logic   valid;
        drink_e drink;
    } select_t;

    typedef struct packed {
        logic   valid;
        drink_e drink;
    } vend_event_t;

    // Bit index equals the drink_e value
    typedef logic [3:0] lamps_t;

    // ==========================================================
    // Money, prices and key codes
    // ==========================================================

    localparam credit_t CREDIT_MAX  = 7'd100;
    localparam credit_t COIN_UNIT   = 7'd5;
    localparam credit_t COIN_15_VAL = 7'd15;
    localparam credit_t COIN_50_VAL = 7'd50;

    localparam credit_t PRICE_0 = 7'd80;
    localparam credit_t PRICE_1 = 7'd30;
    localparam credit_t PRICE_2 = 7'd25;
    localparam credit_t PRICE_3 = 7'd20;

    localparam logic [7:0] KEY_0 = 8'h45;
    localparam logic [7:0] KEY_1 = 8'h16;
    localparam logic [7:0] KEY_2 = 8'h1E;
    localparam logic [7:0] KEY_3 = 8'h26;

    localparam int DEBOUNCE_DEPTH_DEF = 4;
    localparam int REFUND_PERIOD_DEF  = 50_000_000;

    // Price table lookup
    function automatic credit_t drink_price(drink_e drink);
        case (drink)
            DRINK_0: return PRICE_0;
            DRINK_1: return PRICE_1;
            DRINK_2: return PRICE_2;
            default: return PRICE_3;
        endcase
    endfunction

endpackage

// ==== hdl/disp_pkg.sv ====
package disp_pkg;

    // Decimal digit, or DIGIT_BLANK for a dark position
    typedef logic [3:0] digit_t;

    // Active low, a in bit 7 down to g in bit 1, dp in bit 0
    typedef logic [7:0] seg_t;

    // Active-low digit enables
    typedef logic [3:0] anode_t;

    localparam digit_t DIGIT_BLANK = 4'd10;
    localparam seg_t   SEG_BLANK   = 8'hFF;
    localparam anode_t AN_OFF      = 4'hF;

    localparam int SCAN_PERIOD_DEF = 65_536;

    // ==========================================================
    // Segment patterns
    // ==========================================================

    function automatic seg_t seg_pattern(digit_t digit);
        case (digit)
            4'd0:    return 8'b0000_0011;
            4'd1:    return 8'b1001_1111;
            4'd2:    return 8'b0010_0101;
            4'd3:    return 8'b0000_1101;
            4'd4:    return 8'b1001_1001;
            4'd5:    return 8'b0100_1001;
            4'd6:    return 8'b0100_0001;
            4'd7:    return 8'b0001_1011;
            4'd8:    return 8'b0000_0001;
            4'd9:    return 8'b0000_1001;
            default: return SEG_BLANK;
        endcase
    endfunction

endpackage

// ==== hdl/button_conditioner.sv ====
module button_conditioner #(
    parameter int DEBOUNCE_DEPTH = vend_pkg::DEBOUNCE_DEPTH_DEF
) (
    input  logic clk,
    input  logic rst,
    input  logic raw,
    output logic press
);

    // Sample history, newest sample in bit 0
    logic [DEBOUNCE_DEPTH-1:0] samples;

    // Debounced level and its one-cycle delayed copy
    logic level;
    logic level_d;

    // Stable only after DEBOUNCE_DEPTH high samples in a row
    assign level = &samples;

    // ==========================================================
    // Sampling and rising-edge detect
    // ==========================================================

    // Depth of at least two is expected here
    always_ff @(posedge clk) begin
        if (rst) begin
            samples <= '0;
            level_d <= 1'b0;
            press   <= 1'b0;
        end else begin
            samples <= {samples[DEBOUNCE_DEPTH-2:0], raw};
            level_d <= level;
            // One pulse per press, holding the button gives nothing more
            press   <= level & ~level_d;
        end
    end

endmodule

// ==== hdl/key_selector.sv ====
module key_selector (
    input  logic              clk,
    input  logic              rst,
    input  logic [7:0]        key_code,
    input  logic              key_valid,
    output vend_pkg::select_t select
);

    import vend_pkg::*;

    logic   hit;
    drink_e hit_drink;
    logic   sel_valid;
    drink_e sel_drink;

    // Scan code to drink lookup
    always_comb begin
        hit       = 1'b1;
        hit_drink = DRINK_0;
        case (key_code)
            KEY_0:   hit_drink = DRINK_0;
            KEY_1:   hit_drink = DRINK_1;
            KEY_2:   hit_drink = DRINK_2;
            KEY_3:   hit_drink = DRINK_3;
            default: hit = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sel_valid <= 1'b0;
        end else begin
            // Unknown codes vanish here
            sel_valid <= key_valid & hit;
        end
    end

    always_ff @(posedge clk) begin
        if (key_valid && hit) begin
            sel_drink <= hit_drink;
        end
    end

    assign select = '{valid: sel_valid, drink: sel_drink};

    // Back-to-back selections need back-to-back key strobes
    a_no_stretch: assert property (
        @(posedge clk) disable iff (rst)
        (select.valid && $past(select.valid)) |-> $past(key_valid) && $past(key_valid, 2)
    );

endmodule

// ==== hdl/vend_controller.sv ====
module vend_controller #(
    parameter int REFUND_PERIOD = vend_pkg::REFUND_PERIOD_DEF
) (
    input  logic                  clk,
    input  logic                  rst,
    input  vend_pkg::buttons_t    buttons,
    input  vend_pkg::select_t     select,
    output vend_pkg::vend_event_t dispense,
    output logic                  refund_coin,
    output vend_pkg::lamps_t      lamps,
    output vend_pkg::credit_t     credit
);

    import vend_pkg::*;

    localparam int CNT_W = (REFUND_PERIOD > 1) ? $clog2(REFUND_PERIOD) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(REFUND_PERIOD - 1);

    state_e           state;
    state_e           state_next;
    credit_t          credit_next;
    logic [CNT_W-1:0] refund_cnt;
    credit_t          sel_price;
    logic             buy;
    logic             refund_tick;
    logic             disp_valid;
    drink_e           disp_drink;

    // Add a coin, clamp at the coin box limit
    function automatic credit_t sat_add(credit_t base, credit_t coin);
        logic [7:0] sum;
        sum = {1'b0, base} + {1'b0, coin};
        return (sum > {1'b0, CREDIT_MAX}) ? CREDIT_MAX : sum[6:0];
    endfunction

    // ==========================================================
    // Purchase check and refund pacing
    // ==========================================================

    assign sel_price   = drink_price(select.drink);
    assign buy         = (state == COLLECT) && select.valid && (sel_price <= credit);
    assign refund_tick = (state == REFUND) && (refund_cnt == CNT_LAST);

    // An accepted purchase beats any coin in the same cycle
    always_comb begin
        state_next  = state;
        credit_next = credit;
        case (state)
            COLLECT: begin
                if (buy) begin
                    credit_next = credit - sel_price;
                    if (credit != sel_price) begin
                        state_next = REFUND;
                    end
                end else if (buttons.coin_5) begin
                    credit_next = sat_add(credit, COIN_UNIT);
                end else if (buttons.coin_15) begin
                    credit_next = sat_add(credit, COIN_15_VAL);
                end else if (buttons.coin_50) begin
                    credit_next = sat_add(credit, COIN_50_VAL);
                end else if (buttons.cancel && credit != '0) begin
                    state_next = REFUND;
                end
            end
            REFUND: begin
                if (refund_tick) begin
                    credit_next = (credit > COIN_UNIT) ? credit - COIN_UNIT : '0;
                    // Last coin out
                    if (credit <= COIN_UNIT) begin
                        state_next = COLLECT;
                    end
                end
            end
            default: begin
                state_next = COLLECT;
            end
        endcase
    end

    // ==========================================================
    // State, credit and event registers
    // ==========================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= COLLECT;
            credit      <= '0;
            refund_cnt  <= '0;
            disp_valid  <= 1'b0;
            refund_coin <= 1'b0;
        end else begin
            state       <= state_next;
            credit      <= credit_next;
            disp_valid  <= buy;
            refund_coin <= refund_tick;
            // Counter restarts on every coin and stays at zero outside REFUND
            if (state != REFUND || refund_tick) begin
                refund_cnt <= '0;
            end else begin
                refund_cnt <= refund_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (buy) begin
            disp_drink <= select.drink;
        end
    end

    assign dispense = '{valid: disp_valid, drink: disp_drink};

    // Lamp per drink, lit when credit covers its price
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            lamps[i] = (credit >= drink_price(drink_e'(i)));
        end
    end

    a_credit_max: assert property (
        @(posedge clk) disable iff (rst)
        credit <= CREDIT_MAX
    );

    a_no_overlap: assert property (
        @(posedge clk) disable iff (rst)
        !(dispense.valid && refund_coin)
    );

    // Coin pulse lands one cycle after a REFUND tick
    a_refund_state: assert property (
        @(posedge clk) disable iff (rst)
        refund_coin |-> $past(state) == REFUND
    );

endmodule

// ==== hdl/seg_display.sv ====
module seg_display #(
    parameter int SCAN_PERIOD = disp_pkg::SCAN_PERIOD_DEF
) (
    input  logic              clk,
    input  logic              rst,
    input  vend_pkg::credit_t credit,
    output disp_pkg::anode_t  an,
    output disp_pkg::seg_t    seg
);

    import disp_pkg::*;

    localparam int CNT_W = (SCAN_PERIOD > 1) ? $clog2(SCAN_PERIOD) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(SCAN_PERIOD - 1);

    logic [CNT_W-1:0] scan_cnt;
    logic             scan_tick;
    logic [1:0]       pos;
    digit_t           units;
    digit_t           tens;
    digit_t           hundreds;
    digit_t           cur_digit;
    anode_t           cur_an;

    // ==========================================================
    // Decimal split with leading blanks
    // ==========================================================

    // Units always lit so zero credit shows a single 0
    always_comb begin
        units    = digit_t'(credit % 10);
        tens     = (credit >= 10) ? digit_t'((credit / 10) % 10) : DIGIT_BLANK;
        hundreds = (credit >= 100) ? digit_t'(credit / 100) : DIGIT_BLANK;
    end

    // Position select
    always_comb begin
        case (pos)
            2'd0: begin
                cur_an    = 4'b1110;
                cur_digit = units;
            end
            2'd1: begin
                cur_an    = 4'b1101;
                cur_digit = tens;
            end
            2'd2: begin
                cur_an    = 4'b1011;
                cur_digit = hundreds;
            end
            default: begin
                // Fourth slot stays dark
                cur_an    = AN_OFF;
                cur_digit = DIGIT_BLANK;
            end
        endcase
    end

    // ==========================================================
    // Scan timing
    // ==========================================================

    assign scan_tick = (scan_cnt == CNT_LAST);

    always_ff @(posedge clk) begin
        if (rst) begin
            scan_cnt <= '0;
            pos      <= 2'd0;
            an       <= AN_OFF;
            seg      <= SEG_BLANK;
        end else if (scan_tick) begin
            scan_cnt <= '0;
            pos      <= pos + 2'd1;
            an       <= cur_an;
            seg      <= seg_pattern(cur_digit);
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    a_one_anode: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(~an)
    );

endmodule

// ==== hdl/vending_top.sv ====
module vending_top #(
    parameter int DEBOUNCE_DEPTH = vend_pkg::DEBOUNCE_DEPTH_DEF,
    parameter int REFUND_PERIOD  = vend_pkg::REFUND_PERIOD_DEF,
    parameter int SCAN_PERIOD    = disp_pkg::SCAN_PERIOD_DEF
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  btn_coin_5,
    input  logic                  btn_coin_15,
    input  logic                  btn_coin_50,
    input  logic                  btn_cancel,
    input  logic [7:0]            key_code,
    input  logic                  key_valid,
    output vend_pkg::vend_event_t dispense,
    output logic                  refund_coin,
    output vend_pkg::lamps_t      lamps,
    output vend_pkg::credit_t     credit,
    output disp_pkg::anode_t      an,
    output disp_pkg::seg_t        seg
);

    import vend_pkg::*;

    logic     press_coin_5;
    logic     press_coin_15;
    logic     press_coin_50;
    logic     press_cancel;
    buttons_t buttons;
    select_t  select;

    // ==========================================================
    // Button conditioning
    // ==========================================================

    button_conditioner #(.DEBOUNCE_DEPTH(DEBOUNCE_DEPTH)) i_cond_coin_5 (
        .clk(clk), .rst(rst), .raw(btn_coin_5), .press(press_coin_5)
    );

    button_conditioner #(.DEBOUNCE_DEPTH(DEBOUNCE_DEPTH)) i_cond_coin_15 (
        .clk(clk), .rst(rst), .raw(btn_coin_15), .press(press_coin_15)
    );

    button_conditioner #(.DEBOUNCE_DEPTH(DEBOUNCE_DEPTH)) i_cond_coin_50 (
        .clk(clk), .rst(rst), .raw(btn_coin_50), .press(press_coin_50)
    );

    button_conditioner #(.DEBOUNCE_DEPTH(DEBOUNCE_DEPTH)) i_cond_cancel (
        .clk(clk), .rst(rst), .raw(btn_cancel), .press(press_cancel)
    );

    assign buttons = '{
        coin_5:  press_coin_5,
        coin_15: press_coin_15,
        coin_50: press_coin_50,
        cancel:  press_cancel
    };

    // Keyboard selection
    key_selector i_key_selector (
        .clk(clk), .rst(rst), .key_code(key_code), .key_valid(key_valid), .select(select)
    );

    // ==========================================================
    // Controller and display
    // ==========================================================

    vend_controller #(.REFUND_PERIOD(REFUND_PERIOD)) i_vend_controller (
        .clk(clk), .rst(rst), .buttons(buttons), .select(select),
        .dispense(dispense), .refund_coin(refund_coin), .lamps(lamps), .credit(credit)
    );

    seg_display #(.SCAN_PERIOD(SCAN_PERIOD)) i_seg_display (
        .clk(clk), .rst(rst), .credit(credit), .an(an), .seg(seg)
    );

endmodule

// ==== testbench/vending_tb.sv ====
module vending_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import vend_pkg::*;
    import disp_pkg::*;

    localparam int DEBOUNCE      = 4;
    localparam int REFUND_PERIOD = 20;
    localparam int SCAN_PERIOD   = 8;

    // Directed presses, keys and display scans, then the random ops
    localparam int PRESS_OPS   = 300;
    localparam int REFUND_OPS  = 210;
    localparam int CYCLE_LIMIT = 2 * (PRESS_OPS * 16 + REFUND_OPS * 20 * REFUND_PERIOD);

    typedef enum int {BTN_5, BTN_15, BTN_50, BTN_CANCEL} button_e;

    typedef struct packed {
        int          cycle;
        vend_event_t ev;
    } disp_exp_t;

    logic        clk;
    logic        rst;
    logic [3:0]  btn_raw;
    logic [7:0]  key_code;
    logic        key_valid;
    vend_event_t dispense;
    logic        refund_coin;
    lamps_t      lamps;
    credit_t     credit;
    anode_t      an;
    seg_t        seg;

    int          cycle_cnt = 0;
    int          dispense_seen = 0;
    int          dispense_expected = 0;
    int          refund_seen = 0;
    int          refund_expected = 0;
    integer      seed;
    credit_t     model_credit = '0;
    bit          in_refund = 1'b0;
    disp_exp_t   exp_q[$];

    vending_top #(
        .DEBOUNCE_DEPTH(DEBOUNCE),
        .REFUND_PERIOD(REFUND_PERIOD),
        .SCAN_PERIOD(SCAN_PERIOD)
    ) i_vending_top (
        .clk(clk), .rst(rst),
        .btn_coin_5(btn_raw[BTN_5]), .btn_coin_15(btn_raw[BTN_15]),
        .btn_coin_50(btn_raw[BTN_50]), .btn_cancel(btn_raw[BTN_CANCEL]),
        .key_code(key_code), .key_valid(key_valid),
        .dispense(dispense), .refund_coin(refund_coin), .lamps(lamps),
        .credit(credit), .an(an), .seg(seg)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // ==========================================================
    // Reference model
    // ==========================================================

    function automatic credit_t add_coin(credit_t c, int value);
        int sum;
        sum = int'(c) + value;
        return (sum > 100) ? credit_t'(100) : credit_t'(sum);
    endfunction

    function automatic credit_t price_of(drink_e drink);
        case (drink)
            DRINK_0: return PRICE_0;
            DRINK_1: return PRICE_1;
            DRINK_2: return PRICE_2;
            default: return PRICE_3;
        endcase
    endfunction

    function automatic bit decode_key(input logic [7:0] code, output drink_e drink);
        drink = DRINK_0;
        case (code)
            KEY_0: drink = DRINK_0;
            KEY_1: drink = DRINK_1;
            KEY_2: drink = DRINK_2;
            KEY_3: drink = DRINK_3;
            default: return 1'b0;
        endcase
        return 1'b1;
    endfunction

    function automatic lamps_t expected_lamps(credit_t c);
        return {c >= PRICE_3, c >= PRICE_2, c >= PRICE_1, c >= PRICE_0};
    endfunction

    // Lit segments as a..g active high, then inverted with dp off
    function automatic seg_t expected_seg(credit_t c, int pos);
        int         digit;
        logic [6:0] lit;
        digit = -1;
        if (pos == 0) digit = c % 10;
        if (pos == 1 && c >= 10) digit = (c / 10) % 10;
        if (pos == 2 && c >= 100) digit = c / 100;
        case (digit)
            0: lit = 7'h7E;
            1: lit = 7'h30;
            2: lit = 7'h6D;
            3: lit = 7'h79;
            4: lit = 7'h33;
            5: lit = 7'h5B;
            6: lit = 7'h5F;
            7: lit = 7'h72;
            8: lit = 7'h7F;
            9: lit = 7'h7B;
            default: lit = 7'h00;
        endcase
        return {~lit, 1'b1};
    endfunction

    // ==========================================================
    // Compare tasks
    // ==========================================================

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic compare_credit(input string name, input credit_t exp, input credit_t act);
        if (exp !== act) begin
            $display("error %s expected %h actual %h", name, exp, act);
            report_failure("credit mismatch");
        end
    endtask

    task automatic compare_event(input string name, input vend_event_t exp,
                                 input vend_event_t act);
        if (exp !== act) begin
            $display("error %s expected %h actual %h", name, exp, act);
            report_failure("dispense mismatch");
        end
    endtask

    task automatic compare_lamps(input string name, input lamps_t exp, input lamps_t act);
        if (exp !== act) begin
            $display("error %s expected %h actual %h", name, exp, act);
            report_failure("lamps mismatch");
        end
    endtask

    task automatic compare_seg(input string name, input seg_t exp, input seg_t act);
        if (exp !== act) begin
            $display("error %s expected %h actual %h", name, exp, act);
            report_failure("segment mismatch");
        end
    endtask

    task automatic check_model_state;
        compare_credit("credit", model_credit, credit);
        compare_lamps("lamps", expected_lamps(model_credit), lamps);
    endtask

    // Dispense is compared on every cycle, expected or not
    always @(negedge clk) begin
        disp_exp_t   entry;
        vend_event_t exp_ev;
        vend_event_t act_ev;
        if (!rst) begin
            exp_ev = '0;
            if (exp_q.size() > 0 && exp_q[0].cycle == cycle_cnt) begin
                entry  = exp_q.pop_front();
                exp_ev = entry.ev;
            end
            act_ev = dispense.valid ? dispense : '0;
            compare_event("dispense", exp_ev, act_ev);
            if (dispense.valid) dispense_seen++;
            if (refund_coin) refund_seen++;
        end
    end

    initial begin
        wait (cycle_cnt >= CYCLE_LIMIT);
        $display("Timeout: the run took more than %0d cycles", CYCLE_LIMIT);
        $display("Errors found");
        $fatal(1);
    end

    // ==========================================================
    // Stimulus tasks
    // ==========================================================

    task automatic press_button(input button_e kind, input int hold);
        bit ignore;
        ignore = in_refund;
        @(posedge clk);
        btn_raw[kind] <= 1'b1;
        repeat (hold) @(posedge clk);
        btn_raw[kind] <= 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        if (!ignore && hold >= DEBOUNCE) begin
            case (kind)
                BTN_5:   model_credit = add_coin(model_credit, 5);
                BTN_15:  model_credit = add_coin(model_credit, 15);
                BTN_50:  model_credit = add_coin(model_credit, 50);
                default: in_refund = (model_credit != 0);
            endcase
        end
        if (!ignore) check_model_state();
    endtask

    task automatic send_key(input logic [7:0] code);
        bit        ignore;
        bit        buy;
        drink_e    drink;
        credit_t   price;
        disp_exp_t entry;
        ignore = in_refund;
        buy    = decode_key(code, drink);
        price  = price_of(drink);
        buy    = buy && !ignore && (price <= model_credit);
        @(posedge clk);
        key_code  <= code;
        key_valid <= 1'b1;
        // Counter still holds its old value at this edge
        if (buy) begin
            entry.cycle = cycle_cnt + 3;
            entry.ev    = '{valid: 1'b1, drink: drink};
            exp_q.push_back(entry);
        end
        @(posedge clk);
        key_valid <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        if (buy) begin
            model_credit = model_credit - price;
            in_refund    = (model_credit != 0);
            dispense_expected++;
        end
        if (!ignore) check_model_state();
    endtask

    task automatic finish_refund;
        int coins;
        int gap;
        int i;
        coins = model_credit / 5;
        for (i = 0; i < coins; i++) begin
            gap = 0;
            do begin
                @(negedge clk);
                gap++;
            end while (!refund_coin && gap < 2 * REFUND_PERIOD);
            if (!refund_coin) report_failure("refund coin did not arrive in time");
            if (i > 0 && gap != REFUND_PERIOD) report_failure("refund coins not evenly spaced");
            model_credit = model_credit - 5;
            compare_credit("credit", model_credit, credit);
        end
        refund_expected += coins;
        in_refund = 1'b0;
        check_model_state();
    endtask

    // Lets one scan pass so every latched digit reflects the current credit
    task automatic check_display;
        int         pos;
        logic [3:0] seen;
        seen = '0;
        repeat (SCAN_PERIOD + 1) @(negedge clk);
        repeat (4 * SCAN_PERIOD) begin
            @(negedge clk);
            if (!$onehot0(~an)) report_failure("more than one anode is driven low");
            case (an)
                4'b1110: pos = 0;
                4'b1101: pos = 1;
                4'b1011: pos = 2;
                4'b1111: pos = 3;
                default: report_failure("anode of the unused fourth digit is driven low");
            endcase
            seen[pos] = 1'b1;
            compare_seg("seg", expected_seg(model_credit, pos), seg);
        end
        if (seen != 4'hF) report_failure("the display did not scan all four digit positions");
    endtask

    // ==========================================================
    // Test sequence
    // ==========================================================

    initial begin
        int         op;
        logic [7:0] code;
        clk       = 1'b0;
        rst       = 1'b1;
        btn_raw   = '0;
        key_code  = '0;
        key_valid = 1'b0;
        seed      = 61618;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_model_state();

        // Coins and saturation
        press_button(BTN_5, 8);
        check_display();
        press_button(BTN_15, 8);
        press_button(BTN_50, 8);
        check_display();
        press_button(BTN_50, 8);
        press_button(BTN_5, 8);
        check_display();

        // Purchases, unknown code and short credit
        send_key(8'h99);
        send_key(KEY_0);
        finish_refund();
        press_button(BTN_15, 8);
        send_key(KEY_3);
        press_button(BTN_5, 8);
        send_key(KEY_3);
        check_display();

        // Cancel, with input arriving during the refund
        press_button(BTN_50, 8);
        press_button(BTN_15, 8);
        press_button(BTN_CANCEL, 8);
        fork
            finish_refund();
            begin
                press_button(BTN_5, 8);
                send_key(KEY_3);
                press_button(BTN_CANCEL, 8);
            end
        join
        press_button(BTN_5, 8);
        press_button(BTN_CANCEL, 8);
        finish_refund();

        // Debounce
        press_button(BTN_15, 3);
        press_button(BTN_15, 30);
        press_button(BTN_CANCEL, 8);
        finish_refund();

        // Random operations
        repeat (200) begin
            op = $unsigned($random(seed)) % 10;
            if (op < 3) press_button(BTN_5, 8);
            else if (op < 5) press_button(BTN_15, 8);
            else if (op == 5) press_button(BTN_50, 8);
            else if (op == 6) press_button(BTN_CANCEL, 8);
            else begin
                case ($unsigned($random(seed)) % 5)
                    0: code = KEY_0;
                    1: code = KEY_1;
                    2: code = KEY_2;
                    3: code = KEY_3;
                    default: code = 8'h5A;
                endcase
                send_key(code);
            end
            if (in_refund) finish_refund();
        end
        check_display();

        repeat (4) @(negedge clk);
        if (dispense_seen != dispense_expected) report_failure("wrong number of dispenses");
        if (refund_seen != refund_expected) report_failure("wrong number of refund coins");
        if (exp_q.size() != 0) report_failure("an expected dispense never came");
        $display("No errors");
        $finish;
    end

endmodule

// ==== src.f ====
hdl/vend_pkg.sv
hdl/disp_pkg.sv
hdl/button_conditioner.sv
hdl/key_selector.sv
hdl/vend_controller.sv
hdl/seg_display.sv
hdl/vending_top.sv
testbench/vending_tb.sv
